// ==== design/mcu_addr_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcu_addr_ctrl
  import mcu_cmd_pkg::*, mcu_mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_ready,
  input  logic      param_ready,
  input  cmd_byte_t cmd_data,
  input  cmd_byte_t param_data,
  input  byte_cnt_t spi_byte_cnt,
  input  logic      mcu_rq_rdy,
  output mem_addr_t addr_out,
  output logic      mcu_rrq,
  output logic      mcu_wrq,
  output mem_data_t mcu_data_out,
  output logic      read_done
);

  logic [1:0] rdy_sr;
  logic       rdy_rise;
  logic       done_q;
  logic       is_read;
  logic       is_write;
  logic       inc_en;
  byte_cnt_t  inc_threshold;

  assign is_read  = (cmd_data[7:4] == op_mem_read);
  assign is_write = (cmd_data[7:4] == op_mem_write);

  // rising edge of the memory ready, one cycle after first sample
  assign rdy_rise = rdy_sr[0] & ~rdy_sr[1];

  // with the delay bit the command byte does not step
  assign inc_threshold = 8'd1 + byte_cnt_t'(cmd_data[inc_delay_bit]);
  assign inc_en = done_q && (is_read || is_write) && cmd_data[auto_inc_bit]
                  && (spi_byte_cnt >= inc_threshold);

  ////////////////////////////////////////////////////////////////////////////
  // requests and completion
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_sr    <= 2'b00;
      done_q    <= 1'b0;
      read_done <= 1'b0;
      mcu_rrq   <= 1'b0;
      mcu_wrq   <= 1'b0;
    end else begin
      rdy_sr    <= {rdy_sr[0], mcu_rq_rdy};
      done_q    <= rdy_rise;
      read_done <= rdy_rise & is_read;
      // read also fires on the command byte to prefetch
      mcu_rrq   <= (cmd_ready | param_ready) & is_read;
      mcu_wrq   <= param_ready & is_write;
    end
  end

  always_ff @(posedge clk) begin
    if (param_ready && is_write) begin
      mcu_data_out <= param_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // address pointer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_out <= '0;
    end else if (param_ready && cmd_data[7:4] == op_addr_set) begin
      case (spi_byte_cnt)
        8'd2: addr_out <= {param_data, 16'h0000};
        8'd3: addr_out[15:8] <= param_data;
        8'd4: addr_out[7:0] <= param_data;
        default: ;
      endcase
    end else if (inc_en) begin
      addr_out <= addr_out + 24'd1;
    end
  end

  a_rrq_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    mcu_rrq |=> !mcu_rrq);

  a_wrq_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    mcu_wrq |=> !mcu_wrq);

endmodule

`default_nettype wire

// ==== design/mcu_cmd_config.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcu_cmd_config
  import mcu_cmd_pkg::*, mcu_mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_ready,
  input  logic      param_ready,
  input  cmd_byte_t cmd_data,
  input  cmd_byte_t param_data,
  input  byte_cnt_t spi_byte_cnt,
  output mapper_t   mcu_mapper,
  output mem_mask_t rom_mask_out,
  output mem_mask_t saveram_mask_out,
  output feature_t  featurebits_out,
  output logic      region_out
);

  // high byte of the feature word, held until the low byte arrives
  cmd_byte_t feat_stage;

  // put one parameter byte into a 24-bit mask, msb first
  function automatic mem_mask_t place_mask_byte(
    input mem_mask_t cur,
    input byte_cnt_t cnt,
    input cmd_byte_t b
  );
    mem_mask_t res;
    res = cur;
    case (cnt)
      8'd2: res[23:16] = b;
      8'd3: res[15:8] = b;
      8'd4: res[7:0] = b;
      default: ;
    endcase
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // register bank
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcu_mapper       <= mapper_reset;
      rom_mask_out     <= '0;
      saveram_mask_out <= '0;
      featurebits_out  <= '0;
      region_out       <= 1'b0;
    end else if (cmd_ready) begin
      // mapper comes with the command byte itself
      if (cmd_data[7:4] == op_mapper) begin
        mcu_mapper <= cmd_data[2:0];
      end
    end else if (param_ready) begin
      case (cmd_data[7:4])
        op_rom_mask:
          rom_mask_out <= place_mask_byte(rom_mask_out, spi_byte_cnt, param_data);
        op_sram_mask:
          saveram_mask_out <= place_mask_byte(saveram_mask_out, spi_byte_cnt, param_data);
        default: ;
      endcase
      // whole word at once on byte 3
      if (cmd_data == op_feature && spi_byte_cnt == 8'd3) begin
        featurebits_out <= {feat_stage, param_data};
      end
      if (cmd_data == op_region) begin
        region_out <= param_data[0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (param_ready && cmd_data == op_feature && spi_byte_cnt == 8'd2) begin
      feat_stage <= param_data;
    end
  end

  // mapper numbers above 7 would be cut to three bits
  a_mapper_range: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_ready && cmd_data[7:4] == op_mapper) |-> !cmd_data[3]);

endmodule

`default_nettype wire

// ==== design/mcu_cmd_pkg.sv ====
`default_nettype none

package mcu_cmd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // SPI byte types
  ////////////////////////////////////////////////////////////////////////////

  // command or parameter byte as shifted in from SPI
  typedef logic [7:0] cmd_byte_t;

  // position in the transfer, the command byte is 1
  typedef logic [7:0] byte_cnt_t;

  ////////////////////////////////////////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////////////////////////////////////////

  // matched against the high nibble only
  localparam logic [3:0] op_addr_set  = 4'h0;
  localparam logic [3:0] op_rom_mask  = 4'h1;
  localparam logic [3:0] op_sram_mask = 4'h2;
  localparam logic [3:0] op_mapper    = 4'h3;
  localparam logic [3:0] op_mem_read  = 4'h8;
  localparam logic [3:0] op_mem_write = 4'h9;

  // matched against the full byte
  localparam cmd_byte_t op_feature   = 8'hED;
  localparam cmd_byte_t op_region    = 8'hEE;
  localparam cmd_byte_t op_signature = 8'hF0;
  localparam cmd_byte_t op_echo      = 8'hFF;

  ////////////////////////////////////////////////////////////////////////////
  // response byte
  ////////////////////////////////////////////////////////////////////////////

  localparam cmd_byte_t resp_signature = 8'hA5;
  localparam cmd_byte_t resp_idle      = 8'h00;

  // flag bits inside a memory read/write command byte
  localparam int auto_inc_bit  = 3;
  // with the delay bit the command byte does not step the address
  localparam int inc_delay_bit = 4;

endpackage

`default_nettype wire

// ==== design/mcu_cmd_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcu_cmd_top
  import mcu_cmd_pkg::*, mcu_mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  // spi side
  input  logic      cmd_ready,
  input  logic      param_ready,
  input  cmd_byte_t cmd_data,
  input  cmd_byte_t param_data,
  input  byte_cnt_t spi_byte_cnt,
  output cmd_byte_t spi_data_out,
  // memory side
  output mem_addr_t addr_out,
  output logic      mcu_rrq,
  output logic      mcu_wrq,
  output mem_data_t mcu_data_out,
  input  logic      mcu_rq_rdy,
  input  mem_data_t mcu_data_in,
  // configuration
  output mapper_t   mcu_mapper,
  output mem_mask_t rom_mask_out,
  output mem_mask_t saveram_mask_out,
  output feature_t  featurebits_out,
  output logic      region_out
);

  logic read_done;

  mcu_cmd_config u_config (
    .clk              (clk),
    .rst_n            (rst_n),
    .cmd_ready        (cmd_ready),
    .param_ready      (param_ready),
    .cmd_data         (cmd_data),
    .param_data       (param_data),
    .spi_byte_cnt     (spi_byte_cnt),
    .mcu_mapper       (mcu_mapper),
    .rom_mask_out     (rom_mask_out),
    .saveram_mask_out (saveram_mask_out),
    .featurebits_out  (featurebits_out),
    .region_out       (region_out)
  );

  mcu_addr_ctrl u_addr (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .spi_byte_cnt (spi_byte_cnt),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .addr_out     (addr_out),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_data_out (mcu_data_out),
    .read_done    (read_done)
  );

  mcu_readback u_readback (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .read_done    (read_done),
    .mcu_data_in  (mcu_data_in),
    .spi_data_out (spi_data_out)
  );

endmodule

`default_nettype wire

// ==== design/mcu_mem_pkg.sv ====
`default_nettype none

package mcu_mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // memory side types
  ////////////////////////////////////////////////////////////////////////////

  // byte address into ROM / save RAM space
  typedef logic [23:0] mem_addr_t;

  // address mask, same width as the address
  typedef logic [23:0] mem_mask_t;

  typedef logic [2:0] mapper_t;

  typedef logic [7:0] mem_data_t;

  // feature enables
  typedef logic [15:0] feature_t;

  // mapper selected out of reset
  localparam mapper_t mapper_reset = 3'd1;

endpackage

`default_nettype wire

// ==== design/mcu_readback.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcu_readback
  import mcu_cmd_pkg::*, mcu_mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_ready,
  input  logic      param_ready,
  input  cmd_byte_t cmd_data,
  input  cmd_byte_t param_data,
  input  logic      read_done,
  input  mem_data_t mcu_data_in,
  output cmd_byte_t spi_data_out
);

  logic strobe;
  logic is_sig;
  logic is_echo;

  assign strobe  = cmd_ready | param_ready;
  assign is_sig  = (cmd_data == op_signature);
  assign is_echo = (cmd_data == op_echo);

  ////////////////////////////////////////////////////////////////////////////
  // response byte
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      spi_data_out <= resp_idle;
    end else if (read_done) begin
      // memory data wins, it only comes during a read command
      spi_data_out <= mcu_data_in;
    end else if (strobe && is_sig) begin
      spi_data_out <= resp_signature;
    end else if (param_ready && is_echo) begin
      spi_data_out <= param_data;
    end
  end

  // a read completion cannot overlap an echo transfer
  a_no_echo_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(read_done && strobe && is_echo));

endmodule

`default_nettype wire

// ==== flist.f ====
design/mcu_cmd_pkg.sv
design/mcu_mem_pkg.sv
design/mcu_cmd_config.sv
design/mcu_addr_ctrl.sv
design/mcu_readback.sv
design/mcu_cmd_top.sv
test/tb_mcu_cmd.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the command decoder testbench with Verilator and run it

cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_mcu_cmd -f flist.f -o sim_mcu_cmd &&
./obj_dir/sim_mcu_cmd | tee /dev/stderr | grep -F -- '** PASS **' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== test/tb_mcu_cmd.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mcu_cmd
  import mcu_cmd_pkg::*, mcu_mem_pkg::*;
();

  // check codes, select the output compared after a row
  localparam logic [3:0] chk_none   = 4'd0;
  localparam logic [3:0] chk_mapper = 4'd1;
  localparam logic [3:0] chk_rom    = 4'd2;
  localparam logic [3:0] chk_sram   = 4'd3;
  localparam logic [3:0] chk_feat   = 4'd4;
  localparam logic [3:0] chk_region = 4'd5;
  localparam logic [3:0] chk_addr   = 4'd6;
  localparam logic [3:0] chk_resp   = 4'd7;
  localparam logic [3:0] chk_mem    = 4'd8;

  localparam logic s_cmd = 1'b0;
  localparam logic s_prm = 1'b1;

  typedef struct packed {
    logic        is_param;
    cmd_byte_t   cmd;
    cmd_byte_t   prm;
    byte_cnt_t   cnt;
    logic [3:0]  chk;
    logic [23:0] expv;
  } row_t;

  logic      clk;
  logic      rst_n;
  logic      cmd_ready;
  logic      param_ready;
  cmd_byte_t cmd_data;
  cmd_byte_t param_data;
  byte_cnt_t spi_byte_cnt;
  cmd_byte_t spi_data_out;
  mem_addr_t addr_out;
  logic      mcu_rrq;
  logic      mcu_wrq;
  mem_data_t mcu_data_out;
  logic      mcu_rq_rdy;
  mem_data_t mcu_data_in;
  mapper_t   mcu_mapper;
  mem_mask_t rom_mask_out;
  mem_mask_t saveram_mask_out;
  feature_t  featurebits_out;
  logic      region_out;

  row_t      rows [0:63];
  int        n_rows = 0;
  bit        table_built = 1'b0;
  int        rrq_cnt = 0;
  int        wrq_cnt = 0;
  integer    seed;
  mem_data_t mem [0:255];
  mem_data_t ref_mem [0:255];
  mem_addr_t exp_addr;
  cmd_byte_t exp_resp;

  mcu_cmd_top u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .cmd_ready        (cmd_ready),
    .param_ready      (param_ready),
    .cmd_data         (cmd_data),
    .param_data       (param_data),
    .spi_byte_cnt     (spi_byte_cnt),
    .spi_data_out     (spi_data_out),
    .addr_out         (addr_out),
    .mcu_rrq          (mcu_rrq),
    .mcu_wrq          (mcu_wrq),
    .mcu_data_out     (mcu_data_out),
    .mcu_rq_rdy       (mcu_rq_rdy),
    .mcu_data_in      (mcu_data_in),
    .mcu_mapper       (mcu_mapper),
    .rom_mask_out     (rom_mask_out),
    .saveram_mask_out (saveram_mask_out),
    .featurebits_out  (featurebits_out),
    .region_out       (region_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    int          dly;
    mem_data_t   rd_byte;
    mcu_rq_rdy = 1'b0;
    mcu_data_in = '0;
    seed = 32'h265dbaf1;
    for (int i = 0; i < 256; i++) begin
      rnd = $random(seed);
      mem[i] = rnd[7:0];
    end
    forever begin
      @(posedge clk);
      if (mcu_rrq || mcu_wrq) begin
        if (mcu_wrq) begin
          mem[addr_out[7:0]] = mcu_data_out;
        end
        rd_byte = mem[addr_out[7:0]];
        rnd = $random(seed);
        // ready 1 to 4 cycles after the request
        dly = int'(rnd[1:0]) + 1;
        repeat (dly - 1) @(posedge clk);
        mcu_rq_rdy <= 1'b1;
        mcu_data_in <= rd_byte;
        @(posedge clk);
        mcu_rq_rdy <= 1'b0;
      end
    end
  end

  // request pulse counters
  always @(posedge clk) begin
    if (mcu_rrq) begin
      rrq_cnt <= rrq_cnt + 1;
    end
    if (mcu_wrq) begin
      wrq_cnt <= wrq_cnt + 1;
    end
  end

  initial begin
    wait (table_built);
    repeat (200 * (n_rows + 2)) @(posedge clk);
    $display("Error: simulation timed out after %0t, a handshake never finished", $time);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [23:0] want,
                             input logic [23:0] got);
    assert (got == want) else begin
      $display("Error: time %0t, %s expected 0x%06h, got 0x%06h", $time, name, want, got);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_row(input logic p, input cmd_byte_t c, input cmd_byte_t prm,
                         input byte_cnt_t cnt, input logic [3:0] chk,
                         input logic [23:0] expv);
    row_t r;
    r.is_param = p;
    r.cmd = c;
    r.prm = prm;
    r.cnt = cnt;
    r.chk = chk;
    r.expv = expv;
    rows[n_rows] = r;
    n_rows = n_rows + 1;
  endtask

  // strobe, command, parameter, byte count, check, expected value
  task automatic build_table();
    add_row(s_cmd, 8'h33, 8'h00, 8'd1, chk_mapper, 24'h000003);
    add_row(s_cmd, 8'h10, 8'h00, 8'd1, chk_none,   24'h000000);
    add_row(s_prm, 8'h10, 8'h3F, 8'd2, chk_rom,    24'h3F0000);
    add_row(s_prm, 8'h10, 8'hFF, 8'd3, chk_rom,    24'h3FFF00);
    add_row(s_prm, 8'h10, 8'hFF, 8'd4, chk_rom,    24'h3FFFFF);
    add_row(s_cmd, 8'h20, 8'h00, 8'd1, chk_none,   24'h000000);
    add_row(s_prm, 8'h20, 8'h01, 8'd2, chk_sram,   24'h010000);
    add_row(s_prm, 8'h20, 8'hFF, 8'd3, chk_sram,   24'h01FF00);
    add_row(s_prm, 8'h20, 8'hFF, 8'd4, chk_sram,   24'h01FFFF);
    // feature word only appears after its low byte
    add_row(s_cmd, 8'hED, 8'h00, 8'd1, chk_none,   24'h000000);
    add_row(s_prm, 8'hED, 8'h12, 8'd2, chk_feat,   24'h000000);
    add_row(s_prm, 8'hED, 8'h34, 8'd3, chk_feat,   24'h001234);
    add_row(s_cmd, 8'hEE, 8'h00, 8'd1, chk_none,   24'h000000);
    add_row(s_prm, 8'hEE, 8'h01, 8'd2, chk_region, 24'h000001);
    // pointer to 0x000010, then reads with auto-increment
    add_row(s_cmd, 8'h00, 8'h00, 8'd1, chk_none,   24'h000000);
    add_row(s_prm, 8'h00, 8'h00, 8'd2, chk_addr,   24'h000000);
    add_row(s_prm, 8'h00, 8'h00, 8'd3, chk_addr,   24'h000000);
    add_row(s_prm, 8'h00, 8'h10, 8'd4, chk_addr,   24'h000010);
    add_row(s_cmd, 8'h88, 8'h00, 8'd1, chk_mem,    24'h000000);
    add_row(s_prm, 8'h88, 8'h00, 8'd2, chk_mem,    24'h000000);
    add_row(s_prm, 8'h88, 8'h00, 8'd3, chk_mem,    24'h000000);
    add_row(s_prm, 8'h88, 8'h00, 8'd4, chk_mem,    24'h000000);
    // writes with the delay bit
    add_row(s_cmd, 8'h98, 8'h00, 8'd1, chk_mem,    24'h000000);
    add_row(s_prm, 8'h98, 8'hA1, 8'd2, chk_mem,    24'h000000);
    add_row(s_prm, 8'h98, 8'hB2, 8'd3, chk_mem,    24'h000000);
    add_row(s_prm, 8'h98, 8'hC3, 8'd4, chk_mem,    24'h000000);
    // read the written bytes back
    add_row(s_cmd, 8'h00, 8'h00, 8'd1, chk_none,   24'h000000);
    add_row(s_prm, 8'h00, 8'h00, 8'd2, chk_addr,   24'h000000);
    add_row(s_prm, 8'h00, 8'h00, 8'd3, chk_addr,   24'h000000);
    add_row(s_prm, 8'h00, 8'h14, 8'd4, chk_addr,   24'h000014);
    add_row(s_cmd, 8'h88, 8'h00, 8'd1, chk_mem,    24'h000000);
    add_row(s_prm, 8'h88, 8'h00, 8'd2, chk_mem,    24'h000000);
    add_row(s_prm, 8'h88, 8'h00, 8'd3, chk_mem,    24'h000000);
    add_row(s_cmd, 8'hF0, 8'h00, 8'd1, chk_resp,   24'h0000A5);
    add_row(s_cmd, 8'hFF, 8'h00, 8'd1, chk_none,   24'h000000);
    add_row(s_prm, 8'hFF, 8'h5C, 8'd2, chk_resp,   24'h00005C);
  endtask

  // reference side of an access: data, memory contents and pointer step
  task automatic update_reference(input row_t r, input logic is_rd);
    byte_cnt_t thr;
    thr = 8'd1 + {7'd0, r.cmd[inc_delay_bit]};
    if (is_rd) begin
      exp_resp = ref_mem[exp_addr[7:0]];
    end else begin
      ref_mem[exp_addr[7:0]] = r.prm;
    end
    if (r.cmd[auto_inc_bit] && r.cnt >= thr) begin
      exp_addr = exp_addr + 24'd1;
    end
  endtask

  task automatic check_row(input row_t r, input logic is_rd, input logic is_wr);
    case (r.chk)
      chk_mapper: check_value("mcu_mapper", r.expv, {21'd0, mcu_mapper});
      chk_rom:    check_value("rom_mask_out", r.expv, rom_mask_out);
      chk_sram:   check_value("saveram_mask_out", r.expv, saveram_mask_out);
      chk_feat:   check_value("featurebits_out", r.expv, {8'd0, featurebits_out});
      chk_region: check_value("region_out", r.expv, {23'd0, region_out});
      chk_resp:   check_value("spi_data_out", r.expv, {16'd0, spi_data_out});
      chk_addr: begin
        check_value("addr_out", r.expv, addr_out);
        exp_addr = r.expv;
      end
      chk_mem: begin
        check_value("addr_out", exp_addr, addr_out);
        if (is_rd) begin
          check_value("spi_data_out", {16'd0, exp_resp}, {16'd0, spi_data_out});
        end
        if (is_wr && r.is_param) begin
          check_value("mcu_data_out", {16'd0, r.prm}, {16'd0, mcu_data_out});
        end
      end
      default: ;
    endcase
  endtask

  task automatic apply_row(input row_t r);
    int   rrq_start;
    int   wrq_start;
    logic is_rd;
    logic is_wr;
    logic mem_access;
    rrq_start = rrq_cnt;
    wrq_start = wrq_cnt;
    is_rd = (r.cmd[7:4] == op_mem_read);
    is_wr = (r.cmd[7:4] == op_mem_write);
    mem_access = is_rd || (is_wr && r.is_param);
    @(posedge clk);
    cmd_data <= r.cmd;
    param_data <= r.prm;
    spi_byte_cnt <= r.cnt;
    if (r.is_param) begin
      param_ready <= 1'b1;
    end else begin
      cmd_ready <= 1'b1;
    end
    @(posedge clk);
    cmd_ready <= 1'b0;
    param_ready <= 1'b0;
    if (mem_access) begin
      do @(negedge clk); while (!mcu_rq_rdy);
      // completion two edges after ready is first sampled
      repeat (3) @(posedge clk);
      update_reference(r, is_rd);
    end
    @(negedge clk);
    check_row(r, is_rd, is_wr);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value("mcu_rrq pulses", {23'd0, is_rd}, 24'(rrq_cnt - rrq_start));
    check_value("mcu_wrq pulses", {23'd0, is_wr && r.is_param}, 24'(wrq_cnt - wrq_start));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    cmd_ready = 1'b0;
    param_ready = 1'b0;
    cmd_data = '0;
    param_data = '0;
    spi_byte_cnt = '0;
    build_table();
    table_built = 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("mcu_mapper", {21'd0, mapper_reset}, {21'd0, mcu_mapper});
    check_value("addr_out", 24'h000000, addr_out);
    check_value("rom_mask_out", 24'h000000, rom_mask_out);
    check_value("saveram_mask_out", 24'h000000, saveram_mask_out);
    check_value("featurebits_out", 24'h000000, {8'd0, featurebits_out});
    check_value("region_out", 24'h000000, {23'd0, region_out});
    check_value("spi_data_out", {16'd0, resp_idle}, {16'd0, spi_data_out});
    // idle bus, no requests expected
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("mcu_rrq pulses", 24'd0, 24'(rrq_cnt));
    check_value("mcu_wrq pulses", 24'd0, 24'(wrq_cnt));
    ref_mem = mem;
    exp_addr = '0;
    exp_resp = resp_idle;
    for (int i = 0; i < n_rows; i++) begin
      apply_row(rows[i]);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire
